//--- synth_pkg.sv
`default_nettype none

package synth_pkg;

    //////////////////////////////////////////////////////////////////////
    // index and datapath widths
    //////////////////////////////////////////////////////////////////////
    localparam int V_WIDTH     = 3;  // voice index
    localparam int E_WIDTH     = 3;  // envelope index within a voice
    localparam int O_WIDTH     = 2;  // oscillator index within a voice
    localparam int PHASE_WIDTH = 24; // phase and frequency word

    typedef logic [V_WIDTH-1:0]         voice_t;
    typedef logic [E_WIDTH-1:0]         env_t;
    typedef logic [V_WIDTH+O_WIDTH-1:0] osc_sel_t; // voice-major, linear
    typedef logic [PHASE_WIDTH-1:0]     phase_t;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    // env sits in the low bits and counts fastest
    typedef struct packed {
        voice_t voice;
        env_t   env;
    } slot_idx_t;

    typedef struct packed {
        logic     we;
        osc_sel_t osc;
        phase_t   word;
    } freq_wr_t;

    typedef struct packed {
        logic     valid;
        osc_sel_t osc;
        phase_t   phase;
    } osc_sample_t;

endpackage

`default_nettype wire

//--- tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int DIV = 3
) (
    input  logic trig_rising,
    input  logic xxxx_zero,
    input  logic run,
    output logic tick
);

    localparam int CW = (DIV > 2) ? $clog2(DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(DIV - 1);

    logic [CW-1:0] cnt; // cycles since last wrap

    //////////////////////////////////////////////////////////////////////
    // free-running count while the frame is active
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;                  // realign for the next frame
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one-cycle strobe on the last count, sampled at the wrap edge
    assign tick = run && (cnt == LAST);

endmodule

`default_nettype wire

//--- slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer #(
    parameter int VOICES = 4,
    parameter int V_ENVS = 4
) (
    input  logic                  trig_rising,
    input  logic                  xxxx_zero,
    input  logic                  env_tick,
    output synth_pkg::slot_idx_t  slot,
    output logic                  frame_done
);

    localparam synth_pkg::voice_t LAST_VOICE = synth_pkg::voice_t'(VOICES - 1);
    localparam synth_pkg::env_t   LAST_ENV   = synth_pkg::env_t'(V_ENVS - 1);

    logic env_wrap;   // env field at its top value
    logic slot_last;  // final voice/env pair of the frame

    assign env_wrap  = (slot.env == LAST_ENV);
    assign slot_last = env_wrap && (slot.voice == LAST_VOICE);

    //////////////////////////////////////////////////////////////////////
    // nested voice/env counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            slot <= '0;
        end else if (env_tick) begin
            if (slot_last) begin
                slot <= '0;                          // frame wraps
            end else if (env_wrap) begin
                slot.env   <= '0;
                slot.voice <= slot.voice + 1'b1;     // carry into voice
            end else begin
                slot.env <= slot.env + 1'b1;
            end
        end
    end

    // end-of-frame pulse, raised on the wrapping tick
    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= env_tick && slot_last;
        end
    end

endmodule

`default_nettype wire

//--- synth_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module synth_clk_gen #(
    parameter int VOICES  = 4,
    parameter int V_OSC   = 2,
    parameter int OSC_DIV = 3,
    parameter int ENV_DIV = 5
) (
    input  logic                  trig_rising,
    input  logic                  xxxx_zero,
    input  logic                  trig,
    output logic                  run,
    output logic                  osc_tick,
    output logic                  env_tick,
    output synth_pkg::slot_idx_t  slot,
    output logic                  frame_done
);

    // two envelopes per oscillator
    localparam int V_ENVS = 2 * V_OSC;

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t state;
    logic   trig_q;     // trig sampled at the previous edge
    logic   trig_edge;

    //////////////////////////////////////////////////////////////////////
    // trigger edge detect and run FSM
    //////////////////////////////////////////////////////////////////////
    assign trig_edge = trig && !trig_q;

    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= trig;
        end
    end

    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (trig_edge)  state <= RUN;   // edges in RUN are dropped
                RUN:     if (frame_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign run = (state == RUN);

    //////////////////////////////////////////////////////////////////////
    // tick strobes and slot counter
    //////////////////////////////////////////////////////////////////////
    tick_divider #(.DIV(OSC_DIV)) osc_div_inst (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .run         (run),
        .tick        (osc_tick)
    );

    tick_divider #(.DIV(ENV_DIV)) env_div_inst (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .run         (run),
        .tick        (env_tick)
    );

    slot_sequencer #(
        .VOICES (VOICES),
        .V_ENVS (V_ENVS)
    ) slot_seq_inst (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .env_tick    (env_tick),
        .slot        (slot),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

//--- phase_accum_bank.sv
`timescale 1ns/1ps
`default_nettype none

module phase_accum_bank #(
    parameter int VOICES = 4,
    parameter int V_OSC  = 2
) (
    input  logic                    trig_rising,
    input  logic                    xxxx_zero,
    input  logic                    run,
    input  logic                    osc_tick,
    input  synth_pkg::freq_wr_t     freq_wr,
    output synth_pkg::osc_sample_t  osc_out
);

    localparam int NUM_OSC = VOICES * V_OSC;
    localparam int IDX_W   = (NUM_OSC > 1) ? $clog2(NUM_OSC) : 1;
    localparam synth_pkg::osc_sel_t LAST_OSC = synth_pkg::osc_sel_t'(NUM_OSC - 1);

    synth_pkg::phase_t   freq_mem  [NUM_OSC];  // host-written increments
    synth_pkg::phase_t   phase_mem [NUM_OSC];
    synth_pkg::osc_sel_t ptr;                  // oscillator served next
    synth_pkg::phase_t   next_phase;
    logic [IDX_W-1:0]    ptr_idx;
    logic [IDX_W-1:0]    wr_idx;
    logic                wr_ok;

    assign ptr_idx    = ptr[IDX_W-1:0];
    assign wr_idx     = freq_wr.osc[IDX_W-1:0];
    assign wr_ok      = freq_wr.we && (freq_wr.osc <= LAST_OSC);  // drop out-of-range
    assign next_phase = phase_mem[ptr_idx] + freq_mem[ptr_idx];   // wraps mod 2^24

    //////////////////////////////////////////////////////////////////////
    // frequency table
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            for (int i = 0; i < NUM_OSC; i++) begin
                freq_mem[i] <= '0;
            end
        end else if (wr_ok) begin
            freq_mem[wr_idx] <= freq_wr.word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // phase update and round-robin pointer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trig_rising or posedge xxxx_zero) begin
        if (xxxx_zero) begin
            for (int i = 0; i < NUM_OSC; i++) begin
                phase_mem[i] <= '0;
            end
            ptr     <= '0;
            osc_out <= '0;
        end else begin
            osc_out.valid <= osc_tick;
            if (osc_tick) begin
                phase_mem[ptr_idx] <= next_phase;
                osc_out.osc        <= ptr;          // sample payload for this tick
                osc_out.phase      <= next_phase;
            end
            if (!run) begin
                ptr <= '0;                       // each frame starts at osc 0
            end else if (osc_tick) begin
                ptr <= (ptr == LAST_OSC) ? '0 : ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- synth_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module synth_timing_top #(
    parameter int VOICES  = 4,
    parameter int V_OSC   = 2,
    parameter int OSC_DIV = 3,
    parameter int ENV_DIV = 5
) (
    input  logic                    trig_rising,
    input  logic                    xxxx_zero,
    input  logic                    trig,
    input  synth_pkg::freq_wr_t     freq_wr,
    output logic                    run,
    output logic                    env_tick,
    output synth_pkg::slot_idx_t    slot,
    output logic                    frame_done,
    output synth_pkg::osc_sample_t  osc_out
);

    logic osc_tick; // clock gen to accumulators

    synth_clk_gen #(
        .VOICES  (VOICES),
        .V_OSC   (V_OSC),
        .OSC_DIV (OSC_DIV),
        .ENV_DIV (ENV_DIV)
    ) clk_gen_inst (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .trig        (trig),
        .run         (run),
        .osc_tick    (osc_tick),
        .env_tick    (env_tick),
        .slot        (slot),
        .frame_done  (frame_done)
    );

    phase_accum_bank #(
        .VOICES (VOICES),
        .V_OSC  (V_OSC)
    ) accum_inst (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .run         (run),
        .osc_tick    (osc_tick),
        .freq_wr     (freq_wr),
        .osc_out     (osc_out)
    );

endmodule

`default_nettype wire

//--- synth_timing_sva.sv
`timescale 1ns/1ps
`default_nettype none

module synth_timing_sva (
    input logic                   trig_rising,
    input logic                   xxxx_zero,
    input logic                   run,
    input logic                   env_tick,
    input logic                   frame_done,
    input synth_pkg::osc_sample_t osc_out
);

    //////////////////////////////////////////////////////////////////////
    // frame boundary
    //////////////////////////////////////////////////////////////////////
    done_one_cycle: assert property (@(posedge trig_rising) disable iff (xxxx_zero)
        frame_done |=> !frame_done)
        else $error("frame_done held for more than one cycle");

    run_falls_after_done: assert property (@(posedge trig_rising) disable iff (xxxx_zero)
        frame_done |=> !run)
        else $error("run still high the cycle after frame_done");

    //////////////////////////////////////////////////////////////////////
    // strobes only inside a frame
    //////////////////////////////////////////////////////////////////////
    env_tick_in_run: assert property (@(posedge trig_rising) disable iff (xxxx_zero)
        env_tick |-> run)
        else $error("env_tick while run is low");

    valid_after_run: assert property (@(posedge trig_rising) disable iff (xxxx_zero)
        osc_out.valid |-> $past(run))   // one cycle behind the tick
        else $error("osc_out.valid without a preceding run cycle");

endmodule

bind synth_timing_top synth_timing_sva sva_inst (
    .trig_rising (trig_rising),
    .xxxx_zero   (xxxx_zero),
    .run         (run),
    .env_tick    (env_tick),
    .frame_done  (frame_done),
    .osc_out     (osc_out)
);

`default_nettype wire

//--- tb_synth_timing.sv
`timescale 1ns/1ps
`default_nettype none

module tb_synth_timing;

    localparam int VOICES    = 4;
    localparam int V_OSC     = 2;
    localparam int OSC_DIV   = 3;
    localparam int ENV_DIV   = 5;
    localparam int V_ENVS    = 2 * V_OSC;
    localparam int NUM_OSC   = VOICES * V_OSC;
    localparam int N_SLOTS   = VOICES * V_ENVS;
    localparam int DONE_CYC  = N_SLOTS * ENV_DIV;   // run rise to frame_done
    localparam int RUN_CYC   = DONE_CYC + 1;        // cycles of run high
    localparam int N_FRAMES  = 3;
    localparam int MAX_GAP   = 6;
    localparam int WD_CYCLES = 20 + N_FRAMES * (RUN_CYC + MAX_GAP + 2 * NUM_OSC + 4) + 100;

    logic                   trig_rising;
    logic                   xxxx_zero;
    logic                   trig;
    synth_pkg::freq_wr_t    freq_wr;
    logic                   run;
    logic                   env_tick;
    logic                   frame_done;
    synth_pkg::slot_idx_t   slot;
    synth_pkg::osc_sample_t osc_out;

    int                errors;
    int                next_osc;       // model oscillator pointer
    int                strobe_count;   // osc_out strobes in this frame
    synth_pkg::phase_t model_freq  [NUM_OSC];
    synth_pkg::phase_t model_phase [NUM_OSC];

    synth_timing_top #(
        .VOICES  (VOICES),
        .V_OSC   (V_OSC),
        .OSC_DIV (OSC_DIV),
        .ENV_DIV (ENV_DIV)
    ) dut (
        .trig_rising (trig_rising),
        .xxxx_zero   (xxxx_zero),
        .trig        (trig),
        .freq_wr     (freq_wr),
        .run         (run),
        .env_tick    (env_tick),
        .slot        (slot),
        .frame_done  (frame_done),
        .osc_out     (osc_out)
    );

    initial trig_rising = 1'b0;
    always #5 trig_rising = ~trig_rising;

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_val("run", run, 0);
        check_val("env_tick", env_tick, 0);
        check_val("frame_done", frame_done, 0);
        check_val("osc_out.valid", osc_out.valid, 0);
        check_val("slot", slot, 0);
    endtask

    task automatic check_osc_sample(input bit exp_valid);
        synth_pkg::phase_t exp_phase;
        check_val("osc_out.valid", osc_out.valid, exp_valid);
        if (osc_out.valid) begin
            strobe_count++;   // every strobe the DUT raises
        end
        if (exp_valid && osc_out.valid) begin
            exp_phase = model_phase[next_osc] + model_freq[next_osc];  // wraps mod 2^24
            check_val("osc_out.osc", osc_out.osc, next_osc);
            check_val("osc_out.phase", osc_out.phase, exp_phase);
            model_phase[next_osc] = exp_phase;
            next_osc = (next_osc == NUM_OSC - 1) ? 0 : next_osc + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic write_freq(input int osc, input synth_pkg::phase_t word);
        @(negedge trig_rising);
        freq_wr.we   = 1'b1;
        freq_wr.osc  = synth_pkg::osc_sel_t'(osc);
        freq_wr.word = word;
        @(negedge trig_rising);
        freq_wr.we   = 1'b0;
        model_freq[osc] = word;
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge trig_rising);
            check_idle_outputs();
        end
    endtask

    // play one frame from the trig edge until run drops and check every cycle
    task automatic play_frame(input bit retrig);
        int c;
        int s;
        @(negedge trig_rising);
        trig = 1'b1;
        @(negedge trig_rising);   // edge sampling trig has passed
        next_osc     = 0;
        strobe_count = 0;
        c            = 0;
        do begin
            s = (c / ENV_DIV) % N_SLOTS;
            check_val("run", run, 1);
            check_val("env_tick", env_tick, (c % ENV_DIV) == ENV_DIV - 1);
            check_val("slot", slot, ((s / V_ENVS) << synth_pkg::E_WIDTH) | (s % V_ENVS));
            check_val("frame_done", frame_done, c == DONE_CYC);
            check_osc_sample(c > 0 && (c % OSC_DIV) == 0);
            if (c == 2) trig = 1'b0;
            if (retrig && c == 20) trig = 1'b1;   // edge inside the frame
            if (retrig && c == 30) trig = 1'b0;
            @(negedge trig_rising);
            c++;
        end while (run && c < RUN_CYC + 4);
        check_val("run high cycles", c, RUN_CYC);
        check_val("frame_done", frame_done, 0);
        check_val("env_tick", env_tick, 0);
        check_osc_sample((c % OSC_DIV) == 0);     // tick on the last run cycle
        check_val("osc strobes per frame", strobe_count, RUN_CYC / OSC_DIV);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_quiet();
        repeat (8) begin
            @(negedge trig_rising);
            check_idle_outputs();
        end
        xxxx_zero = 1'b0;
        idle_gap(4);
    endtask

    task automatic single_frame_run();
        for (int i = 0; i < NUM_OSC; i++) begin
            write_freq(i, synth_pkg::phase_t'($urandom));
        end
        play_frame(1'b1);
        idle_gap($urandom_range(MAX_GAP, 1));   // dropped edge must not restart
    endtask

    task automatic back_to_back_frames();
        play_frame(1'b0);
        idle_gap($urandom_range(MAX_GAP, 1));
    endtask

    task automatic rewrite_between_frames();
        int idx;
        idx = $urandom_range(NUM_OSC - 1, 0);
        write_freq(idx, synth_pkg::phase_t'($urandom));
        idle_gap($urandom_range(MAX_GAP, 1));
        play_frame(1'b0);
        idle_gap(2);
    endtask

    initial begin
        void'($urandom(86));
        errors    = 0;
        xxxx_zero = 1'b1;
        trig      = 1'b0;
        freq_wr   = '0;
        for (int i = 0; i < NUM_OSC; i++) begin
            model_freq[i]  = '0;
            model_phase[i] = '0;
        end
        reset_quiet();
        single_frame_run();
        back_to_back_frames();
        rewrite_between_frames();
        $display("Checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog sized from the frame count
    initial begin
        #(WD_CYCLES * 10);
        $display("Timeout: run did not complete within %0d cycles", WD_CYCLES);
        $display("Checks finished with %0d error(s)", errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
synth_pkg.sv
tick_divider.sv
slot_sequencer.sv
synth_clk_gen.sv
phase_accum_bank.sv
synth_timing_top.sv
synth_timing_sva.sv
tb_synth_timing.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_synth_timing
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
FAIL_MSG   := Result: FAILED
PASS_MSG   := Result: PASSED

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
